// File: include/am4_defines.svh
//------------------------------------------------
// width, depth, latency and PSW bit macros for the
// datapath, included by every RTL and bench module
//------------------------------------------------
`ifndef AM4_DEFINES_SVH
`define AM4_DEFINES_SVH

`define AM4_WORD    16      // data path width
`define AM4_REGS    16      // register file depth
`define AM4_RA      4       // register address width

// strobe in to result strobe out, one cycle per stage
`define AM4_LAT     3

`define AM4_PSW_C   0       // carry
`define AM4_PSW_V   1       // overflow
`define AM4_PSW_Z   2       // zero
`define AM4_PSW_N   3       // negative
`define AM4_PSW_T   4       // trace, start of high nibble

`endif

// File: hw/am4_isa_pkg.sv
//------------------------------------------------
// PDP-11 side types, the instruction word with its
// two decodings and the processor status word
//------------------------------------------------
package am4_isa_pkg;

   // double operand format, modes and registers
   typedef struct packed {
      logic [3:0] op;         // opcode incl. byte bit
      logic [2:0] src_mode;   // source addressing mode
      logic [2:0] src_reg;    // source register
      logic [2:0] dst_mode;   // destination mode
      logic [2:0] dst_reg;    // destination register
   } ins_dop_t;

   // branch format
   typedef struct packed {
      logic       grp;        // selects upper half of table
      logic [3:0] op;         // zero for branches
      logic [2:0] cond;       // condition code select
      logic [7:0] offset;     // word offset, unused here
   } ins_br_t;

   typedef union packed {
      ins_dop_t dop;
      ins_br_t  br;
   } ins_t;

   typedef struct packed {
      logic [3:0] hi;         // priority and trace
      logic       n;
      logic       z;
      logic       v;
      logic       c;
   } psw_t;

endpackage

// File: hw/am4_uop_pkg.sv
//------------------------------------------------
// micro-operation field encodings in bit-slice
// order, plus the raw flags passed to the result
//------------------------------------------------
package am4_uop_pkg;

   // R,S operand pairs
   typedef enum logic [2:0] {
      AQ, AB, ZQ, ZB, ZA, DA, DQ, DZ
   } alu_src_e;

   typedef enum logic [2:0] {
      ADD,     // R + S
      SUBR,    // S - R
      SUBS,    // R - S
      OR,
      AND,
      NOTRS,   // ~R & S
      EXOR,
      EXNOR
   } alu_fn_e;

   // shift codes 4..7 not decoded, act as nop
   typedef enum logic [2:0] {
      QREG,    // F to Q
      NOP,
      RAMA,    // F to B, A on output
      RAMF     // F to B
   } alu_dst_e;

   typedef enum logic [1:0] {
      IMM,     // micro-word literal
      PSW,     // current status word
      INS      // instruction register
   } d_src_e;

   typedef enum logic [1:0] {
      WORD, BYTE, LOAD, NONE
   } psw_mode_e;

   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } flags_t;

endpackage

// File: hw/am4_decode.sv
//------------------------------------------------
// decode stage, instruction register, register field
// steering, D source select and branch condition
//------------------------------------------------
`timescale 1ns/1ps
`include "am4_defines.svh"

module am4_decode
(
   input  logic                     pin_clk,
   input  logic                     dclo,
   input  logic                     ir_load_i,    // latch ins_i
   input  logic [`AM4_WORD-1:0]     ins_i,
   input  logic                     uop_stb_i,    // micro-op valid
   input  am4_uop_pkg::alu_src_e    alu_src_i,
   input  am4_uop_pkg::alu_fn_e     alu_fn_i,
   input  am4_uop_pkg::alu_dst_e    alu_dst_i,
   input  logic                     cin_i,
   input  logic [`AM4_RA-1:0]       a_sel_i,
   input  logic                     a_ins_i,      // A from source reg field
   input  logic [`AM4_RA-1:0]       b_sel_i,
   input  logic                     b_ins_i,      // B from dest reg field
   input  am4_uop_pkg::d_src_e      d_src_i,
   input  logic [`AM4_WORD-1:0]     imm_i,
   input  am4_uop_pkg::psw_mode_e   psw_mode_i,
   input  logic                     byte_i,
   input  am4_isa_pkg::psw_t        psw_i,
   output logic                     branch_o,     // condition met
   output logic                     dv_o,
   output logic [`AM4_RA-1:0]       a_adr_o,
   output logic [`AM4_RA-1:0]       b_adr_o,
   output am4_uop_pkg::alu_src_e    alu_src_o,
   output am4_uop_pkg::alu_fn_e     alu_fn_o,
   output am4_uop_pkg::alu_dst_e    alu_dst_o,
   output logic                     cin_o,
   output logic [`AM4_WORD-1:0]     d_o,
   output logic                     byte_o,
   output am4_uop_pkg::psw_mode_e   psw_mode_o
);
   import am4_isa_pkg::*;
   import am4_uop_pkg::*;

   ins_t                ir;         // instruction register
   logic [`AM4_RA-1:0]  a_adr;
   logic [`AM4_RA-1:0]  b_adr;
   logic [`AM4_WORD-1:0] d;
   logic                nv;         // N xor V

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
         ir <= '0;
      else if (ir_load_i)
         ir <= ins_i;
   end

   // field steering, old IR when load and strobe coincide
   assign a_adr = a_ins_i ? {{(`AM4_RA-3){1'b0}}, ir.dop.src_reg} : a_sel_i;
   assign b_adr = b_ins_i ? {{(`AM4_RA-3){1'b0}}, ir.dop.dst_reg} : b_sel_i;

   always_comb
   begin
      case (d_src_i)
         PSW:     d = {{(`AM4_WORD-8){1'b0}}, psw_i};
         INS:     d = ir;
         default: d = imm_i;              // IMM and unused code
      endcase
   end

   assign nv = psw_i.n ^ psw_i.v;

   // PDP-11 branch table
   always_comb
   begin
      case ({ir.br.grp, ir.br.cond})
         4'b0000: branch_o = 1'b0;                 // not a branch
         4'b0001: branch_o = 1'b1;                 // br
         4'b0010: branch_o = ~psw_i.z;             // bne
         4'b0011: branch_o =  psw_i.z;             // beq
         4'b0100: branch_o = ~nv;                  // bge
         4'b0101: branch_o =  nv;                  // blt
         4'b0110: branch_o = ~(nv | psw_i.z);      // bgt
         4'b0111: branch_o =  nv | psw_i.z;        // ble
         4'b1000: branch_o = ~psw_i.n;             // bpl
         4'b1001: branch_o =  psw_i.n;             // bmi
         4'b1010: branch_o = ~(psw_i.c | psw_i.z); // bhi
         4'b1011: branch_o =  psw_i.c | psw_i.z;   // blos
         4'b1100: branch_o = ~psw_i.v;             // bvc
         4'b1101: branch_o =  psw_i.v;             // bvs
         4'b1110: branch_o = ~psw_i.c;             // bcc
         default: branch_o =  psw_i.c;             // bcs
      endcase
   end

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
         dv_o <= 1'b0;
      else
         dv_o <= uop_stb_i;
   end

   always_ff @(posedge pin_clk)
   begin
      if (uop_stb_i)
      begin
         a_adr_o    <= a_adr;
         b_adr_o    <= b_adr;
         alu_src_o  <= alu_src_i;
         alu_fn_o   <= alu_fn_i;
         alu_dst_o  <= alu_dst_i;
         cin_o      <= cin_i;
         d_o        <= d;
         byte_o     <= byte_i;
         psw_mode_o <= psw_mode_i;
      end
   end

endmodule

// File: hw/am4_execute.sv
//------------------------------------------------
// execute stage, register file, Q, bit-slice ALU
// with byte and word flags, then the output register
//------------------------------------------------
`timescale 1ns/1ps
`include "am4_defines.svh"

module am4_execute
(
   input  logic                     pin_clk,
   input  logic                     dclo,
   input  logic                     dv_i,         // decoded op valid
   input  logic [`AM4_RA-1:0]       a_adr_i,
   input  logic [`AM4_RA-1:0]       b_adr_i,
   input  am4_uop_pkg::alu_src_e    alu_src_i,
   input  am4_uop_pkg::alu_fn_e     alu_fn_i,
   input  am4_uop_pkg::alu_dst_e    alu_dst_i,
   input  logic                     cin_i,
   input  logic [`AM4_WORD-1:0]     d_i,
   input  logic                     byte_i,       // flags from bit 7
   input  am4_uop_pkg::psw_mode_e   psw_mode_i,
   output logic                     ev_o,
   output logic [`AM4_WORD-1:0]     y_o,
   output am4_uop_pkg::flags_t      flags_o,
   output am4_uop_pkg::psw_mode_e   psw_mode_o
);
   import am4_uop_pkg::*;

   localparam int HB = `AM4_WORD / 2;     // byte boundary

   logic [`AM4_WORD-1:0] rf [`AM4_REGS];  // register stack
   logic [`AM4_WORD-1:0] q;
   logic [`AM4_WORD-1:0] a;
   logic [`AM4_WORD-1:0] b;
   logic [`AM4_WORD-1:0] r;               // ALU R operand
   logic [`AM4_WORD-1:0] s;               // ALU S operand
   logic [`AM4_WORD-1:0] x;               // adder inputs
   logic [`AM4_WORD-1:0] y;
   logic [HB:0]          sum_lo;
   logic [HB:0]          sum_hi;
   logic [`AM4_WORD-1:0] f;
   logic                 arith;           // flags C and V meaningful
   logic                 v8;
   logic                 v16;
   flags_t               flags;

   assign a = rf[a_adr_i];
   assign b = rf[b_adr_i];

   always_comb
   begin
      case (alu_src_i)
         AQ:      {r, s} = {a, q};
         AB:      {r, s} = {a, b};
         ZQ:      {r, s} = {{`AM4_WORD{1'b0}}, q};
         ZB:      {r, s} = {{`AM4_WORD{1'b0}}, b};
         ZA:      {r, s} = {{`AM4_WORD{1'b0}}, a};
         DA:      {r, s} = {d_i, a};
         DQ:      {r, s} = {d_i, q};
         default: {r, s} = {d_i, {`AM4_WORD{1'b0}}};   // DZ
      endcase
   end

   // carry out of both bytes, no borrow reads as carry set
   always_comb
   begin
      x     = r;
      y     = s;
      arith = 1'b1;
      case (alu_fn_i)
         SUBR:
         begin
            x = s;
            y = ~r;
         end
         SUBS:    y = ~s;
         ADD:     arith = 1'b1;
         default: arith = 1'b0;            // logic ops
      endcase
      sum_lo = {1'b0, x[HB-1:0]} + {1'b0, y[HB-1:0]} + {{HB{1'b0}}, cin_i};
      sum_hi = {1'b0, x[`AM4_WORD-1:HB]} + {1'b0, y[`AM4_WORD-1:HB]}
               + {{HB{1'b0}}, sum_lo[HB]};
      case (alu_fn_i)
         OR:      f = r | s;
         AND:     f = r & s;
         NOTRS:   f = ~r & s;
         EXOR:    f = r ^ s;
         EXNOR:   f = ~(r ^ s);
         default: f = {sum_hi[HB-1:0], sum_lo[HB-1:0]};
      endcase
   end

   assign v8  = arith & (x[HB-1] == y[HB-1]) & (f[HB-1] != x[HB-1]);
   assign v16 = arith & (x[`AM4_WORD-1] == y[`AM4_WORD-1])
                      & (f[`AM4_WORD-1] != x[`AM4_WORD-1]);

   assign flags.c = arith & (byte_i ? sum_lo[HB] : sum_hi[HB]);
   assign flags.v = byte_i ? v8 : v16;
   assign flags.n = byte_i ? f[HB-1] : f[`AM4_WORD-1];
   assign flags.z = byte_i ? (f[HB-1:0] == '0) : (f == '0);

   // written here so the next op reads the new value
   always_ff @(posedge pin_clk)
   begin
      if (dv_i)
      begin
         case (alu_dst_i)
            QREG:       q <= f;
            RAMA, RAMF: rf[b_adr_i] <= f;
            default:    ;                   // nop and shifts
         endcase
      end
   end

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
         ev_o <= 1'b0;
      else
         ev_o <= dv_i;
   end

   always_ff @(posedge pin_clk)
   begin
      if (dv_i)
      begin
         y_o        <= (alu_dst_i == RAMA) ? a : f;
         flags_o    <= flags;
         psw_mode_o <= psw_mode_i;
      end
   end

endmodule

// File: hw/am4_result.sv
//------------------------------------------------
// result stage, PSW update by mode and the
// registered result strobe
//------------------------------------------------
`timescale 1ns/1ps
`include "am4_defines.svh"

module am4_result
(
   input  logic                     pin_clk,
   input  logic                     dclo,
   input  logic                     ev_i,         // execute output valid
   input  logic [`AM4_WORD-1:0]     y_i,
   input  am4_uop_pkg::flags_t      flags_i,
   input  am4_uop_pkg::psw_mode_e   psw_mode_i,
   output logic                     res_stb_o,
   output logic [`AM4_WORD-1:0]     result_o,
   output am4_isa_pkg::psw_t        psw_o
);
   import am4_uop_pkg::*;

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
         psw_o <= '0;
      else if (ev_i)
      begin
         case (psw_mode_i)
            WORD, BYTE:                   // width chosen upstream
            begin
               psw_o[`AM4_PSW_C] <= flags_i.c;
               psw_o[`AM4_PSW_V] <= flags_i.v;
               psw_o[`AM4_PSW_Z] <= flags_i.z;
               psw_o[`AM4_PSW_N] <= flags_i.n;
            end
            LOAD:
            begin
               psw_o[7:`AM4_PSW_T]         <= y_i[7:`AM4_PSW_T];  // priority, trace
               psw_o[`AM4_PSW_N:`AM4_PSW_C] <= y_i[`AM4_PSW_N:`AM4_PSW_C];
            end
            default: ;                    // hold
         endcase
      end
   end

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
         res_stb_o <= 1'b0;
      else
         res_stb_o <= ev_i;
   end

   always_ff @(posedge pin_clk)
   begin
      if (ev_i)
         result_o <= y_i;
   end

endmodule

// File: hw/am4_core.sv
//------------------------------------------------
// datapath top, decode then execute then result,
// fed by one strobed micro-op per cycle
//------------------------------------------------
`timescale 1ns/1ps
`include "am4_defines.svh"

module am4_core
(
   input  logic                     pin_clk,
   input  logic                     dclo,
   input  logic                     ir_load_i,
   input  logic [`AM4_WORD-1:0]     ins_i,
   input  logic                     uop_stb_i,
   input  am4_uop_pkg::alu_src_e    alu_src_i,
   input  am4_uop_pkg::alu_fn_e     alu_fn_i,
   input  am4_uop_pkg::alu_dst_e    alu_dst_i,
   input  logic                     cin_i,
   input  logic [`AM4_RA-1:0]       a_sel_i,
   input  logic                     a_ins_i,
   input  logic [`AM4_RA-1:0]       b_sel_i,
   input  logic                     b_ins_i,
   input  am4_uop_pkg::d_src_e      d_src_i,
   input  logic [`AM4_WORD-1:0]     imm_i,
   input  am4_uop_pkg::psw_mode_e   psw_mode_i,
   input  logic                     byte_i,
   output logic [`AM4_WORD-1:0]     result_o,
   output logic                     res_stb_o,
   output am4_isa_pkg::psw_t        psw_o,
   output logic                     branch_o
);
   import am4_uop_pkg::*;

   logic                 dec_v;          // decode stage outputs
   logic [`AM4_RA-1:0]   dec_a_adr;
   logic [`AM4_RA-1:0]   dec_b_adr;
   alu_src_e             dec_alu_src;
   alu_fn_e              dec_alu_fn;
   alu_dst_e             dec_alu_dst;
   logic                 dec_cin;
   logic [`AM4_WORD-1:0] dec_d;
   logic                 dec_byte;
   psw_mode_e            dec_psw_mode;
   logic                 exe_v;          // execute stage outputs
   logic [`AM4_WORD-1:0] exe_y;
   flags_t               exe_flags;
   psw_mode_e            exe_psw_mode;

   am4_decode dec0
   (
      .pin_clk(pin_clk),
      .dclo(dclo),
      .ir_load_i(ir_load_i),
      .ins_i(ins_i),
      .uop_stb_i(uop_stb_i),
      .alu_src_i(alu_src_i),
      .alu_fn_i(alu_fn_i),
      .alu_dst_i(alu_dst_i),
      .cin_i(cin_i),
      .a_sel_i(a_sel_i),
      .a_ins_i(a_ins_i),
      .b_sel_i(b_sel_i),
      .b_ins_i(b_ins_i),
      .d_src_i(d_src_i),
      .imm_i(imm_i),
      .psw_mode_i(psw_mode_i),
      .byte_i(byte_i),
      .psw_i(psw_o),             // D source and branch test
      .branch_o(branch_o),
      .dv_o(dec_v),
      .a_adr_o(dec_a_adr),
      .b_adr_o(dec_b_adr),
      .alu_src_o(dec_alu_src),
      .alu_fn_o(dec_alu_fn),
      .alu_dst_o(dec_alu_dst),
      .cin_o(dec_cin),
      .d_o(dec_d),
      .byte_o(dec_byte),
      .psw_mode_o(dec_psw_mode)
   );

   am4_execute exe0
   (
      .pin_clk(pin_clk),
      .dclo(dclo),
      .dv_i(dec_v),
      .a_adr_i(dec_a_adr),
      .b_adr_i(dec_b_adr),
      .alu_src_i(dec_alu_src),
      .alu_fn_i(dec_alu_fn),
      .alu_dst_i(dec_alu_dst),
      .cin_i(dec_cin),
      .d_i(dec_d),
      .byte_i(dec_byte),
      .psw_mode_i(dec_psw_mode),
      .ev_o(exe_v),
      .y_o(exe_y),
      .flags_o(exe_flags),
      .psw_mode_o(exe_psw_mode)
   );

   am4_result res0
   (
      .pin_clk(pin_clk),
      .dclo(dclo),
      .ev_i(exe_v),
      .y_i(exe_y),
      .flags_i(exe_flags),
      .psw_mode_i(exe_psw_mode),
      .res_stb_o(res_stb_o),
      .result_o(result_o),
      .psw_o(psw_o)
   );

endmodule

// File: tb/am4_core_props.sv
//------------------------------------------------
// concurrent checks on the datapath top, bound
// into every am4_core instance
//------------------------------------------------
`timescale 1ns/1ps
`include "am4_defines.svh"

module am4_core_props
(
   input  logic                     pin_clk,
   input  logic                     dclo,
   input  logic                     uop_stb_i,
   input  logic                     res_stb_o,
   input  logic [`AM4_WORD-1:0]     result_o,
   input  am4_isa_pkg::psw_t        psw_o
);

   // result strobe is the input strobe delayed by the pipe depth
   a_lat: assert property (@(posedge pin_clk) disable iff (dclo)
      res_stb_o == $past(uop_stb_i, `AM4_LAT))
      else $error("res_stb_o does not follow uop_stb_i by %0d cycles", `AM4_LAT);

   a_known: assert property (@(posedge pin_clk) disable iff (dclo)
      res_stb_o |-> !$isunknown(result_o))
      else $error("result_o unknown while res_stb_o is high");

   // psw only moves on the edge that raises the strobe
   a_psw: assert property (@(posedge pin_clk) disable iff (dclo)
      !$stable(psw_o) |-> res_stb_o)
      else $error("psw_o changed without a result strobe");

endmodule

bind am4_core am4_core_props props0
(
   .pin_clk(pin_clk),
   .dclo(dclo),
   .uop_stb_i(uop_stb_i),
   .res_stb_o(res_stb_o),
   .result_o(result_o),
   .psw_o(psw_o)
);

// File: tb/am4_core_tb.sv
//------------------------------------------------
// testbench for the datapath, plays micro-ops from
// the golden file and checks result, PSW and branch
//------------------------------------------------
`timescale 1ns/1ps
`include "am4_defines.svh"

module am4_core_tb;
   import am4_isa_pkg::*;
   import am4_uop_pkg::*;

   localparam int MAX_REC = 64;

   logic                 pin_clk = 1'b0;
   logic                 dclo;
   logic                 ir_load_i;
   logic [`AM4_WORD-1:0] ins_i;
   logic                 uop_stb_i;
   alu_src_e             alu_src_i;
   alu_fn_e              alu_fn_i;
   alu_dst_e             alu_dst_i;
   logic                 cin_i;
   logic [`AM4_RA-1:0]   a_sel_i;
   logic                 a_ins_i;
   logic [`AM4_RA-1:0]   b_sel_i;
   logic                 b_ins_i;
   d_src_e               d_src_i;
   logic [`AM4_WORD-1:0] imm_i;
   psw_mode_e            psw_mode_i;
   logic                 byte_i;
   logic [`AM4_WORD-1:0] result_o;
   logic                 res_stb_o;
   psw_t                 psw_o;
   logic                 branch_o;

   logic [95:0]          golden [MAX_REC];   // one record per line
   logic [`AM4_WORD-1:0] exp_res_q [$];      // in strobe order
   psw_t                 exp_psw_q [$];
   int                   n_rec = 0;
   int                   errors = 0;
   int                   n_res = 0;
   int                   n_br = 0;
   int                   cycles = 0;
   int                   limit = 0;
   logic                 br_pend = 1'b0;     // branch check due next fall
   logic                 br_exp = 1'b0;

   am4_core dut0
   (
      .pin_clk(pin_clk),
      .dclo(dclo),
      .ir_load_i(ir_load_i),
      .ins_i(ins_i),
      .uop_stb_i(uop_stb_i),
      .alu_src_i(alu_src_i),
      .alu_fn_i(alu_fn_i),
      .alu_dst_i(alu_dst_i),
      .cin_i(cin_i),
      .a_sel_i(a_sel_i),
      .a_ins_i(a_ins_i),
      .b_sel_i(b_sel_i),
      .b_ins_i(b_ins_i),
      .d_src_i(d_src_i),
      .imm_i(imm_i),
      .psw_mode_i(psw_mode_i),
      .byte_i(byte_i),
      .result_o(result_o),
      .res_stb_o(res_stb_o),
      .psw_o(psw_o),
      .branch_o(branch_o)
   );

   always #5 pin_clk = ~pin_clk;            // 10 ns period

   task automatic check_word(input string name, input logic [`AM4_WORD-1:0] got,
                             input logic [`AM4_WORD-1:0] exp);
      if (got !== exp)
      begin
         $display("ERROR %s got %h exp %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_psw(input string name, input psw_t got, input psw_t exp);
      if (got !== exp)
      begin
         $display("ERROR %s got %h exp %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("ERROR %s got %h exp %h", name, got, exp);
         errors++;
      end
   endtask

   // unpack one record onto the DUT pins
   task automatic drive_record(input logic [95:0] rec);
      ins_i      = rec[95:80];
      ir_load_i  = rec[76];
      uop_stb_i  = rec[77];
      a_ins_i    = rec[78];
      b_ins_i    = rec[79];
      alu_src_i  = alu_src_e'(rec[74:72]);
      alu_fn_i   = alu_fn_e'(rec[70:68]);
      alu_dst_i  = alu_dst_e'(rec[66:64]);
      a_sel_i    = rec[63:60];
      b_sel_i    = rec[59:56];
      byte_i     = rec[55];
      cin_i      = rec[54];
      d_src_i    = d_src_e'(rec[53:52]);
      psw_mode_i = psw_mode_e'(rec[49:48]);
      imm_i      = rec[47:32];
      if (rec[77])
      begin
         exp_res_q.push_back(rec[31:16]);
         exp_psw_q.push_back(psw_t'(rec[15:8]));
      end
      br_pend = rec[4];
      br_exp  = rec[0];
   endtask

   // IR loaded on the edge just passed, psw already settled
   task automatic check_pending_branch();
      if (br_pend)
      begin
         check_bit("branch_o", branch_o, br_exp);
         n_br++;
      end
   endtask

   always @(negedge pin_clk)
   begin
      if (!dclo && res_stb_o)
      begin
         if (exp_res_q.size() == 0)
         begin
            $display("result strobe seen with no operation outstanding");
            errors++;
         end
         else
         begin
            check_word("result_o", result_o, exp_res_q.pop_front());
            check_psw("psw_o", psw_o, exp_psw_q.pop_front());
            n_res++;
         end
      end
   end

   always @(posedge pin_clk)
   begin
      cycles++;
      if (limit > 0 && cycles > limit)
      begin
         $display("timeout, run did not finish within %0d cycles", limit);
         $display(">>> FAIL");
         $finish;
      end
   end

   initial
   begin
      drive_record('0);
      dclo = 1'b1;
      for (int i = 0; i < MAX_REC; i++)
         golden[i] = 'x;                    // marks unused slots
      $readmemh("tb/am4_golden.hex", golden);
      while (n_rec < MAX_REC && !$isunknown(golden[n_rec]))
         n_rec++;
      if (n_rec == 0)
      begin
         $display("golden file missing or holds no records");
         errors++;
      end
      limit = n_rec * 4 + 64;
      repeat (16) @(posedge pin_clk);
      @(negedge pin_clk);
      dclo = 1'b0;
      for (int i = 0; i < n_rec; i++)
      begin
         @(negedge pin_clk);
         check_pending_branch();
         drive_record(golden[i]);
      end
      @(negedge pin_clk);
      check_pending_branch();
      drive_record('0);
      while (exp_res_q.size() != 0)
         @(negedge pin_clk);
      repeat (2) @(negedge pin_clk);
      $display("records %0d results %0d branches %0d errors %0d",
               n_rec, n_res, n_br, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: compile.f
+incdir+include
hw/am4_isa_pkg.sv
hw/am4_uop_pkg.sv
hw/am4_decode.sv
hw/am4_execute.sv
hw/am4_result.sv
hw/am4_core.sv
tb/am4_core_props.sv
tb/am4_core_tb.sv

// File: Makefile
# Verilator build and run of the am4 datapath testbench

VERILATOR ?= verilator
TOP       ?= am4_core_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb/am4_golden.hex
// ins_ctl(bload0 stb1 ains2 bins3)_src_fn_dst_asel_bsel_misc(dsrc1:0 cin2 byte3)_mode
// _imm_expres_exppsw_br(bit4 check, bit0 expected); one micro-op or IR load per line
0000_2_7_0_3_0_1_0_3_1234_1234_00_00
0000_2_7_0_3_0_2_0_3_00ff_00ff_00_00
0000_2_7_0_3_0_3_0_3_7fff_7fff_00_00
0000_2_7_0_3_0_4_0_3_8000_8000_00_00
0000_2_7_0_3_0_5_0_3_7f80_7f80_00_00
0000_2_7_0_3_0_6_0_3_8080_8080_00_00
0000_2_4_0_1_1_0_0_3_0000_1234_00_00
0000_2_4_0_1_4_0_0_3_0000_8000_00_00
0000_2_1_0_1_3_4_0_0_0000_ffff_08_00
0000_2_1_0_1_3_4_4_0_0000_0000_05_00
0000_2_1_2_1_3_4_4_0_0000_ffff_0a_00
0000_2_1_1_1_1_2_4_0_0000_eecb_08_00
0000_2_1_2_1_1_2_0_0_0000_1134_01_00
0000_2_1_3_1_1_2_0_0_0000_12ff_00_00
0000_2_1_4_1_3_4_0_0_0000_0000_04_00
0000_2_1_5_1_2_1_0_0_0000_1200_00_00
0000_2_1_6_1_1_2_0_0_0000_12cb_00_00
0000_2_1_7_1_3_4_0_0_0000_0000_04_00
0000_2_1_0_1_5_6_8_1_0000_0000_07_00
0000_2_1_0_1_5_2_8_1_0000_807f_03_00
6042_1_0_0_0_0_0_0_0_0000_0000_00_00
0000_e_1_0_1_f_f_0_0_0000_1333_00_00
60c4_1_0_0_0_0_0_0_0_0000_0000_00_00
0000_e_1_3_1_f_f_0_0_0000_ffff_08_00
0000_2_7_0_1_0_0_2_3_0000_60c4_08_00
0000_2_7_0_1_0_0_0_2_00e5_00e5_e5_00
0000_0_0_0_0_0_0_0_0_0000_0000_00_00
0000_0_0_0_0_0_0_0_0_0000_0000_00_00
0000_1_0_0_0_0_0_0_0_0000_0000_00_10
0100_1_0_0_0_0_0_0_0_0000_0000_00_11
0200_1_0_0_0_0_0_0_0_0000_0000_00_10
0300_1_0_0_0_0_0_0_0_0000_0000_00_11
0400_1_0_0_0_0_0_0_0_0000_0000_00_11
0500_1_0_0_0_0_0_0_0_0000_0000_00_10
0600_1_0_0_0_0_0_0_0_0000_0000_00_10
0700_1_0_0_0_0_0_0_0_0000_0000_00_11
8000_1_0_0_0_0_0_0_0_0000_0000_00_11
8100_1_0_0_0_0_0_0_0_0000_0000_00_10
8200_1_0_0_0_0_0_0_0_0000_0000_00_10
8300_1_0_0_0_0_0_0_0_0000_0000_00_11
8400_1_0_0_0_0_0_0_0_0000_0000_00_11
8500_1_0_0_0_0_0_0_0_0000_0000_00_10
8600_1_0_0_0_0_0_0_0_0000_0000_00_10
8700_1_0_0_0_0_0_0_0_0000_0000_00_11
0000_2_7_0_1_0_0_1_3_0000_00e5_e5_00
0000_2_7_0_0_0_0_0_3_0003_0003_e5_00
0000_2_0_0_3_1_7_0_0_0000_1237_e0_00
0000_2_4_0_1_7_0_0_3_0000_1237_e0_00
0000_2_6_1_1_0_0_4_3_0010_fff3_e0_00
0000_2_1_0_3_7_7_0_0_0000_246e_e0_00
0000_2_4_0_1_7_0_0_3_0000_246e_e0_00
